// File: hw/sb_hdr_consts.svh
`ifndef SB_HDR_CONSTS_SVH
`define SB_HDR_CONSTS_SVH

// --------------------
// header layout
// --------------------

// full sideband header width
`define SB_HDR_W 64

// message code field
`define SB_MSGCODE_LSB 14
`define SB_MSGCODE_MSB 21

// subcode field
`define SB_SUBCODE_LSB 32
`define SB_SUBCODE_MSB 39

// message info field
`define SB_MSGINFO_LSB 40
`define SB_MSGINFO_MSB 55

// --------------------
// message code nibbles
// --------------------

// upper nibble selects the message group
`define SB_GRP_TEST     4'h8
`define SB_GRP_SBINIT   4'h9
`define SB_GRP_MBINIT   4'hA
`define SB_GRP_MBTRAIN  4'hB
`define SB_GRP_RETRAIN  4'hC
`define SB_GRP_TRAINERR 4'hE

// lower nibble selects request or response
`define SB_DIR_REQ  4'h5
`define SB_DIR_RESP 4'hA

`endif

// File: hw/sb_hdr_pkg.sv
`include "sb_hdr_consts.svh"

package sb_hdr_pkg;

	// --------------------
	// message classification
	// --------------------

	// decoded message group, none for unknown nibbles
	typedef enum logic [2:0] {
		GRP_NONE     = 3'd0,
		GRP_TEST     = 3'd1,
		GRP_SBINIT   = 3'd2,
		GRP_MBINIT   = 3'd3,
		GRP_MBTRAIN  = 3'd4,
		GRP_RETRAIN  = 3'd5,
		GRP_TRAINERR = 3'd6
	} msg_group_e;

	// request / response from the low message code nibble
	typedef enum logic [1:0] {
		DIR_REQ  = 2'd0,
		DIR_RESP = 2'd1,
		DIR_NONE = 2'd2
	} msg_dir_e;

	// point or range test type
	typedef enum logic [1:0] {
		SWEEP_POINT = 2'd0,
		SWEEP_RANGE = 2'd2
	} sweep_test_t;

	// --------------------
	// field types
	// --------------------

	// raw header fields
	typedef logic [`SB_SUBCODE_MSB-`SB_SUBCODE_LSB:0] subcode_t;
	typedef logic [`SB_MSGINFO_MSB-`SB_MSGINFO_LSB:0] msg_info_t;

	// decoded outputs
	typedef logic [3:0] msg_no_t;
	typedef logic [2:0] msg_out_info_t;

endpackage

// File: hw/sb_hdr_class_if.sv
interface sb_hdr_class_if import sb_hdr_pkg::*; ();

	// classified message group
	msg_group_e group;

	// request, response or neither
	msg_dir_e   dir;

	// raw subcode byte
	subcode_t   subcode;

	// raw 16-bit info field
	msg_info_t  info;

	// classifier side
	modport src (
		output group,
		output dir,
		output subcode,
		output info
	);

	// table side, pure combinational read
	modport dst (
		input  group,
		input  dir,
		input  subcode,
		input  info
	);

endinterface

// File: hw/sb_msg_classifier.sv
`include "sb_hdr_consts.svh"

module sb_msg_classifier import sb_hdr_pkg::*; (
	input  logic [`SB_HDR_W-1:0] i_header,
	sb_hdr_class_if.src          o_class,
	output logic                 o_is_test,
	output sweep_test_t          o_sweep_sel,
	output logic                 o_sweep_sel_hit
);

	// --------------------
	// field slicing
	// --------------------

	// message code byte
	logic [`SB_MSGCODE_MSB-`SB_MSGCODE_LSB:0] msg_code;
	// subcode byte
	subcode_t   subcode;
	// info field
	msg_info_t  info;
	// decoded group and direction
	msg_group_e grp;
	msg_dir_e   dir;

	assign msg_code = i_header[`SB_MSGCODE_MSB:`SB_MSGCODE_LSB];
	assign subcode  = i_header[`SB_SUBCODE_MSB:`SB_SUBCODE_LSB];
	assign info     = i_header[`SB_MSGINFO_MSB:`SB_MSGINFO_LSB];

	// --------------------
	// group and direction
	// --------------------

	// upper nibble of message code
	always_comb
	begin
		case (msg_code[7:4])
			`SB_GRP_TEST:     grp = GRP_TEST;
			`SB_GRP_SBINIT:   grp = GRP_SBINIT;
			`SB_GRP_MBINIT:   grp = GRP_MBINIT;
			`SB_GRP_MBTRAIN:  grp = GRP_MBTRAIN;
			`SB_GRP_RETRAIN:  grp = GRP_RETRAIN;
			`SB_GRP_TRAINERR: grp = GRP_TRAINERR;
			default:          grp = GRP_NONE;
		endcase
	end

	// lower nibble of message code
	always_comb
	begin
		case (msg_code[3:0])
			`SB_DIR_REQ:  dir = DIR_REQ;
			`SB_DIR_RESP: dir = DIR_RESP;
			default:      dir = DIR_NONE;
		endcase
	end

	// --------------------
	// point / sweep select
	// --------------------

	// test type by subcode, flag set only for listed subcodes
	always_comb
	begin
		o_sweep_sel     = SWEEP_POINT;
		o_sweep_sel_hit = 1'b0;
		case (subcode)
			8'h01, 8'h03, 8'h04:
			begin
				o_sweep_sel     = SWEEP_POINT;
				o_sweep_sel_hit = 1'b1;
			end
			8'h07, 8'h08, 8'h09:
			begin
				o_sweep_sel     = SWEEP_RANGE;
				o_sweep_sel_hit = 1'b1;
			end
			default:
			begin
				o_sweep_sel     = SWEEP_POINT;
				o_sweep_sel_hit = 1'b0;
			end
		endcase
	end

	assign o_is_test = (grp == GRP_TEST);

	// classified fields to the table
	assign o_class.group   = grp;
	assign o_class.dir     = dir;
	assign o_class.subcode = subcode;
	assign o_class.info    = info;

endmodule

// File: hw/sb_msg_number_lut.sv
module sb_msg_number_lut import sb_hdr_pkg::*; (
	sb_hdr_class_if.dst   i_class,
	output msg_no_t       o_msg_no,
	output msg_out_info_t o_msg_info,
	output logic          o_hit
);

	// request / response candidates from the table
	msg_no_t       num_req;
	msg_no_t       num_rsp;
	msg_out_info_t info_req;
	msg_out_info_t info_rsp;
	// subcode known for this group
	logic          known;
	// entry valid regardless of direction nibble
	logic          any_dir;
	// common info slices
	msg_out_info_t info_lo;
	msg_out_info_t info_mid;

	assign info_lo  = i_class.info[2:0];
	assign info_mid = {1'b0, i_class.info[5:4]};

	// --------------------
	// decode table
	// --------------------

	always_comb
	begin
		num_req  = 4'd0;
		num_rsp  = 4'd0;
		info_req = 3'd0;
		info_rsp = 3'd0;
		known    = 1'b1;
		any_dir  = 1'b0;
		case (i_class.group)
			GRP_TEST:
			begin
				case (i_class.subcode)
					8'h01, 8'h07:
					begin
						num_req = 4'd1;
						num_rsp = 4'd2;
					end
					8'h02:
					begin
						num_req = 4'd3;
						num_rsp = 4'd4;
					end
					// response carries info bits 5:4
					8'h03, 8'h0B:
					begin
						num_req  = 4'd5;
						num_rsp  = 4'd6;
						info_rsp = info_mid;
					end
					8'h04, 8'h09:
					begin
						num_req = 4'd7;
						num_rsp = 4'd8;
					end
					8'h08:
					begin
						num_req = 4'd5;
						num_rsp = 4'd6;
					end
					default: known = 1'b0;
				endcase
			end
			GRP_SBINIT:
			begin
				case (i_class.subcode)
					// same number for any nibble
					8'h00:
					begin
						num_req = 4'd3;
						num_rsp = 4'd3;
						any_dir = 1'b1;
					end
					8'h01:
					begin
						num_req = 4'd1;
						num_rsp = 4'd2;
					end
					default: known = 1'b0;
				endcase
			end
			GRP_MBINIT:
			begin
				case (i_class.subcode)
					8'h00, 8'h02, 8'h03, 8'h09, 8'h0D, 8'h11:
					begin
						num_req = 4'd1;
						num_rsp = 4'd2;
					end
					// response carries info bits 2:0
					8'h04, 8'h0A:
					begin
						num_req  = 4'd3;
						num_rsp  = 4'd4;
						info_rsp = info_lo;
					end
					8'h08, 8'h0C, 8'h0F:
					begin
						num_req = 4'd5;
						num_rsp = 4'd6;
					end
					8'h0E, 8'h13:
					begin
						num_req = 4'd3;
						num_rsp = 4'd4;
					end
					8'h10:
					begin
						num_req = 4'd7;
						num_rsp = 4'd8;
					end
					// request carries info bits 2:0
					8'h14:
					begin
						num_req  = 4'd5;
						num_rsp  = 4'd6;
						info_req = info_lo;
					end
					default: known = 1'b0;
				endcase
			end
			GRP_MBTRAIN:
			begin
				case (i_class.subcode)
					8'h00, 8'h02, 8'h04, 8'h05, 8'h06, 8'h08, 8'h0A,
					8'h0C, 8'h0E, 8'h11, 8'h13, 8'h15, 8'h1B:
					begin
						num_req = 4'd1;
						num_rsp = 4'd2;
					end
					8'h01, 8'h03, 8'h07, 8'h09, 8'h0B, 8'h0D,
					8'h10, 8'h12, 8'h14, 8'h16, 8'h1C:
					begin
						num_req = 4'd3;
						num_rsp = 4'd4;
					end
					8'h17, 8'h1D:
					begin
						num_req = 4'd5;
						num_rsp = 4'd6;
					end
					8'h18:
					begin
						num_req = 4'd7;
						num_rsp = 4'd8;
					end
					// request carries info bits 2:0
					8'h1E:
					begin
						num_req  = 4'd7;
						num_rsp  = 4'd8;
						info_req = info_lo;
					end
					8'h19:
					begin
						num_req = 4'd9;
						num_rsp = 4'd10;
					end
					8'h1F:
					begin
						num_req = 4'd11;
						num_rsp = 4'd12;
					end
					default: known = 1'b0;
				endcase
			end
			GRP_RETRAIN:
			begin
				// info bits 2:0 in both directions
				if (i_class.subcode == 8'h01)
				begin
					num_req  = 4'd1;
					num_rsp  = 4'd2;
					info_req = info_lo;
					info_rsp = info_lo;
				end
				else
				begin
					known = 1'b0;
				end
			end
			GRP_TRAINERR:
			begin
				// numbers swapped relative to the usual order
				if (i_class.subcode == 8'h00)
				begin
					num_req = 4'd15;
					num_rsp = 4'd14;
				end
				else
				begin
					known = 1'b0;
				end
			end
			default: known = 1'b0;
		endcase
	end

	// --------------------
	// direction select
	// --------------------

	always_comb
	begin
		o_msg_no   = 4'd0;
		o_msg_info = 3'd0;
		o_hit      = 1'b0;
		if (known && any_dir)
		begin
			o_msg_no = num_req;
			o_hit    = 1'b1;
		end
		else if (known && i_class.dir == DIR_REQ)
		begin
			o_msg_no   = num_req;
			o_msg_info = info_req;
			o_hit      = 1'b1;
		end
		else if (known && i_class.dir == DIR_RESP)
		begin
			o_msg_no   = num_rsp;
			o_msg_info = info_rsp;
			o_hit      = 1'b1;
		end
	end

endmodule

// File: hw/sb_rx_hdr_regs.sv
module sb_rx_hdr_regs import sb_hdr_pkg::*; (
	input  logic          i_clk,
	input  logic          i_rst_n,
	input  logic          i_start_en,
	input  msg_no_t       i_msg_no,
	input  msg_out_info_t i_msg_info,
	input  logic          i_hit,
	input  logic          i_is_test,
	input  sweep_test_t   i_sweep_sel,
	input  logic          i_sweep_sel_hit,
	output msg_no_t       o_msg_no,
	output msg_out_info_t o_msg_info,
	output logic          o_sweep_en,
	output sweep_test_t   o_sweep_sel,
	output logic          o_valid
);

	// --------------------
	// message number / info
	// --------------------

	// load on start with a table entry, hold on miss
	always_ff @(posedge i_clk or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			o_msg_no   <= 4'd0;
			o_msg_info <= 3'd0;
		end
		else if (i_start_en && i_hit)
		begin
			o_msg_no   <= i_msg_no;
			o_msg_info <= i_msg_info;
		end
	end

	// --------------------
	// point / sweep test
	// --------------------

	// enable follows group, type only on known test subcode
	always_ff @(posedge i_clk or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			o_sweep_en  <= 1'b0;
			o_sweep_sel <= SWEEP_POINT;
		end
		else if (i_start_en)
		begin
			o_sweep_en <= i_is_test;
			if (i_is_test && i_sweep_sel_hit)
				o_sweep_sel <= i_sweep_sel;
		end
	end

	// valid one cycle after each start, stays high when back to back
	always_ff @(posedge i_clk or negedge i_rst_n)
	begin
		if (!i_rst_n)
			o_valid <= 1'b0;
		else
			o_valid <= i_start_en;
	end

endmodule

// File: hw/sb_rx_header_decoder.sv
`include "sb_hdr_consts.svh"

module sb_rx_header_decoder import sb_hdr_pkg::*; (
	input  logic                 i_clk,
	input  logic                 i_rst_n,
	input  logic                 i_start_en,
	input  logic [`SB_HDR_W-1:0] i_header,
	output logic                 o_tx_point_sweep_test_en,
	output sweep_test_t          o_tx_point_sweep_test,
	output msg_no_t              o_msg_no,
	output msg_out_info_t        o_msg_info,
	output logic                 o_dec_header_valid
);

	// classifier to register stage
	logic          is_test;
	sweep_test_t   sweep_sel;
	logic          sweep_sel_hit;
	// table to register stage
	msg_no_t       lut_msg_no;
	msg_out_info_t lut_msg_info;
	logic          lut_hit;

	// classified fields, combinational
	sb_hdr_class_if class_if ();

	// --------------------
	// decode path
	// --------------------

	sb_msg_classifier u_classifier (
		.i_header        (i_header),
		.o_class         (class_if.src),
		.o_is_test       (is_test),
		.o_sweep_sel     (sweep_sel),
		.o_sweep_sel_hit (sweep_sel_hit)
	);

	sb_msg_number_lut u_lut (
		.i_class    (class_if.dst),
		.o_msg_no   (lut_msg_no),
		.o_msg_info (lut_msg_info),
		.o_hit      (lut_hit)
	);

	// output registers, one cycle after start
	sb_rx_hdr_regs u_regs (
		.i_clk           (i_clk),
		.i_rst_n         (i_rst_n),
		.i_start_en      (i_start_en),
		.i_msg_no        (lut_msg_no),
		.i_msg_info      (lut_msg_info),
		.i_hit           (lut_hit),
		.i_is_test       (is_test),
		.i_sweep_sel     (sweep_sel),
		.i_sweep_sel_hit (sweep_sel_hit),
		.o_msg_no        (o_msg_no),
		.o_msg_info      (o_msg_info),
		.o_sweep_en      (o_tx_point_sweep_test_en),
		.o_sweep_sel     (o_tx_point_sweep_test),
		.o_valid         (o_dec_header_valid)
	);

endmodule

// File: dv/sb_rx_header_decoder_checker.sv
module sb_rx_header_decoder_checker import sb_hdr_pkg::*; (
	input logic          i_clk,
	input logic          i_rst_n,
	input logic          i_start_en,
	input logic          i_sweep_en,
	input sweep_test_t   i_sweep_sel,
	input msg_no_t       i_msg_no,
	input msg_out_info_t i_msg_info,
	input logic          i_valid
);

	timeunit 1ns;
	timeprecision 1ps;

	// assertion failures so far
	int unsigned fail_count = 0;

	// --------------------
	// valid timing
	// --------------------

	// start edge gives valid on the next edge
	assert property (@(posedge i_clk) disable iff (!i_rst_n)
		i_start_en |=> i_valid)
		else
		begin
			fail_count++;
			$error("valid missing one cycle after start");
		end

	// no start, no valid
	assert property (@(posedge i_clk) disable iff (!i_rst_n)
		!i_start_en |=> !i_valid)
		else
		begin
			fail_count++;
			$error("valid high without a preceding start");
		end

	// --------------------
	// output stability
	// --------------------

	// decoded outputs only move right after a start edge
	assert property (@(posedge i_clk) disable iff (!i_rst_n)
		!$past(i_start_en) |-> $stable({i_sweep_en, i_sweep_sel, i_msg_no, i_msg_info}))
		else
		begin
			fail_count++;
			$error("decoded outputs changed without a start");
		end

	// 13 is not in the decode table
	assert property (@(posedge i_clk) disable iff (!i_rst_n)
		i_msg_no != 4'd13)
		else
		begin
			fail_count++;
			$error("message number 13 seen on output");
		end

endmodule

// attach to every decoder instance
bind sb_rx_header_decoder sb_rx_header_decoder_checker checker_i (
	.i_clk      (i_clk),
	.i_rst_n    (i_rst_n),
	.i_start_en (i_start_en),
	.i_sweep_en (o_tx_point_sweep_test_en),
	.i_sweep_sel(o_tx_point_sweep_test),
	.i_msg_no   (o_msg_no),
	.i_msg_info (o_msg_info),
	.i_valid    (o_dec_header_valid)
);

// File: dv/sb_rx_header_decoder_tb.sv
`include "sb_hdr_consts.svh"

module sb_rx_header_decoder_tb import sb_hdr_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	// one table row, stimulus fields then expected results
	typedef struct packed {
		logic [3:0]    grp;
		logic [3:0]    dir;
		logic [7:0]    sub;
		logic [15:0]   info;
		msg_no_t       no;
		msg_out_info_t oinfo;
		logic          hit;
		logic          sen;
		sweep_test_t   stype;
		logic          gap;
	} row_t;

	// group and direction nibbles, plus one unused value
	localparam logic [3:0] g_test     = `SB_GRP_TEST;
	localparam logic [3:0] g_sbinit   = `SB_GRP_SBINIT;
	localparam logic [3:0] g_mbinit   = `SB_GRP_MBINIT;
	localparam logic [3:0] g_mbtrain  = `SB_GRP_MBTRAIN;
	localparam logic [3:0] g_retrain  = `SB_GRP_RETRAIN;
	localparam logic [3:0] g_trainerr = `SB_GRP_TRAINERR;
	localparam logic [3:0] g_bad      = 4'h3;
	localparam logic [3:0] d_req      = `SB_DIR_REQ;
	localparam logic [3:0] d_rsp      = `SB_DIR_RESP;
	localparam logic [3:0] d_bad      = 4'h3;

	// info a: bits 5:4 = 3, bits 2:0 = 6
	localparam logic [15:0] info_a = 16'h00B6;
	// info b: bits 5:4 = 2, bits 2:0 = 1
	localparam logic [15:0] info_b = 16'h1229;

	logic                 clk = 1'b0;
	logic                 rst_n;
	logic                 start_en;
	logic [`SB_HDR_W-1:0] header;
	logic                 tx_sweep_en;
	sweep_test_t          tx_sweep;
	msg_no_t              msg_no;
	msg_out_info_t        msg_info;
	logic                 hdr_valid;

	// held expectations, misses keep the last hit
	msg_no_t       exp_no;
	msg_out_info_t exp_info;
	logic          exp_sen;
	sweep_test_t   exp_type;

	row_t rows [$];
	int   errors = 0;
	int   checks = 0;
	int   cycles = 0;

	always #50 clk = ~clk;

	sb_rx_header_decoder dut_i (
		.i_clk                    (clk),
		.i_rst_n                  (rst_n),
		.i_start_en               (start_en),
		.i_header                 (header),
		.o_tx_point_sweep_test_en (tx_sweep_en),
		.o_tx_point_sweep_test    (tx_sweep),
		.o_msg_no                 (msg_no),
		.o_msg_info               (msg_info),
		.o_dec_header_valid       (hdr_valid)
	);

	// --------------------
	// timeout
	// --------------------

	// four cycles per row plus reset margin
	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycles >= 4 * rows.size() + 20)
		begin
			$display("timeout reached after %0d cycles, test did not finish", cycles);
			$display("Regression failed");
			$finish;
		end
	end

	// --------------------
	// table helpers
	// --------------------

	task automatic add_row(input logic [3:0] grp, input logic [3:0] dir,
		input logic [7:0] sub, input logic [15:0] info, input msg_no_t no,
		input msg_out_info_t oinfo, input logic hit, input logic sen,
		input sweep_test_t stype, input logic gap);
		row_t r;
		r.grp   = grp;
		r.dir   = dir;
		r.sub   = sub;
		r.info  = info;
		r.no    = no;
		r.oinfo = oinfo;
		r.hit   = hit;
		r.sen   = sen;
		r.stype = stype;
		r.gap   = gap;
		rows.push_back(r);
	endtask

	// random filler, fields placed on top
	function automatic logic [`SB_HDR_W-1:0] build_header(input row_t r);
		logic [`SB_HDR_W-1:0] h;
		h = {$urandom, $urandom};
		h[`SB_MSGCODE_MSB:`SB_MSGCODE_LSB] = {r.grp, r.dir};
		h[`SB_SUBCODE_MSB:`SB_SUBCODE_LSB] = r.sub;
		h[`SB_MSGINFO_MSB:`SB_MSGINFO_LSB] = r.info;
		return h;
	endfunction

	// compare every output against the held model
	task automatic check_outputs(input string tag, input logic exp_valid);
		checks = checks + 1;
		if (hdr_valid !== exp_valid)
		begin
			errors = errors + 1;
			$display("error %0t: %s valid %b, expected %b", $time, tag, hdr_valid, exp_valid);
		end
		if (msg_no !== exp_no)
		begin
			errors = errors + 1;
			$display("error %0t: %s msg_no %0d, expected %0d", $time, tag, msg_no, exp_no);
		end
		if (msg_info !== exp_info)
		begin
			errors = errors + 1;
			$display("error %0t: %s msg_info %0d, expected %0d", $time, tag, msg_info,
				exp_info);
		end
		if (tx_sweep_en !== exp_sen)
		begin
			errors = errors + 1;
			$display("error %0t: %s sweep enable %b, expected %b", $time, tag, tx_sweep_en,
				exp_sen);
		end
		if (tx_sweep !== exp_type)
		begin
			errors = errors + 1;
			$display("error %0t: %s sweep type %0d, expected %0d", $time, tag, tx_sweep,
				exp_type);
		end
	endtask

	// --------------------
	// stimulus table
	// --------------------

	task automatic fill_table();
		// test group, every subcode set, some back to back
		add_row(g_test, d_req, 8'h01, info_a, 4'd1, 3'd0, 1'b1, 1'b1, SWEEP_POINT, 1'b1);
		add_row(g_test, d_rsp, 8'h07, info_a, 4'd2, 3'd0, 1'b1, 1'b1, SWEEP_RANGE, 1'b0);
		// 02 keeps the previous type
		add_row(g_test, d_req, 8'h02, info_a, 4'd3, 3'd0, 1'b1, 1'b1, SWEEP_RANGE, 1'b0);
		add_row(g_test, d_rsp, 8'h02, info_a, 4'd4, 3'd0, 1'b1, 1'b1, SWEEP_RANGE, 1'b1);
		add_row(g_test, d_req, 8'h03, info_a, 4'd5, 3'd0, 1'b1, 1'b1, SWEEP_POINT, 1'b1);
		add_row(g_test, d_rsp, 8'h0B, info_a, 4'd6, 3'd3, 1'b1, 1'b1, SWEEP_POINT, 1'b1);
		add_row(g_test, d_rsp, 8'h03, info_b, 4'd6, 3'd2, 1'b1, 1'b1, SWEEP_POINT, 1'b0);
		add_row(g_test, d_req, 8'h04, info_a, 4'd7, 3'd0, 1'b1, 1'b1, SWEEP_POINT, 1'b1);
		add_row(g_test, d_rsp, 8'h09, info_a, 4'd8, 3'd0, 1'b1, 1'b1, SWEEP_RANGE, 1'b1);
		add_row(g_test, d_req, 8'h08, info_a, 4'd5, 3'd0, 1'b1, 1'b1, SWEEP_RANGE, 1'b1);
		add_row(g_test, d_rsp, 8'h08, info_a, 4'd6, 3'd0, 1'b1, 1'b1, SWEEP_RANGE, 1'b1);
		// sideband init, 00 ignores the direction nibble
		add_row(g_sbinit, d_req, 8'h00, info_a, 4'd3, 3'd0, 1'b1, 1'b0, SWEEP_RANGE, 1'b1);
		add_row(g_sbinit, d_bad, 8'h00, info_a, 4'd3, 3'd0, 1'b1, 1'b0, SWEEP_RANGE, 1'b1);
		add_row(g_sbinit, d_req, 8'h01, info_a, 4'd1, 3'd0, 1'b1, 1'b0, SWEEP_RANGE, 1'b1);
		add_row(g_sbinit, d_rsp, 8'h01, info_a, 4'd2, 3'd0, 1'b1, 1'b0, SWEEP_RANGE, 1'b0);
		// main-band init
		add_row(g_mbinit, d_req, 8'h00, info_a, 4'd1, 3'd0, 1'b1, 1'b0, SWEEP_RANGE, 1'b1);
		add_row(g_mbinit, d_rsp, 8'h11, info_a, 4'd2, 3'd0, 1'b1, 1'b0, SWEEP_RANGE, 1'b1);
		add_row(g_mbinit, d_req, 8'h04, info_a, 4'd3, 3'd0, 1'b1, 1'b0, SWEEP_RANGE, 1'b1);
		add_row(g_mbinit, d_rsp, 8'h04, info_a, 4'd4, 3'd6, 1'b1, 1'b0, SWEEP_RANGE, 1'b1);
		add_row(g_mbinit, d_rsp, 8'h0A, info_b, 4'd4, 3'd1, 1'b1, 1'b0, SWEEP_RANGE, 1'b1);
		add_row(g_mbinit, d_req, 8'h08, info_a, 4'd5, 3'd0, 1'b1, 1'b0, SWEEP_RANGE, 1'b1);
		add_row(g_mbinit, d_rsp, 8'h0F, info_a, 4'd6, 3'd0, 1'b1, 1'b0, SWEEP_RANGE, 1'b1);
		add_row(g_mbinit, d_req, 8'h0E, info_a, 4'd3, 3'd0, 1'b1, 1'b0, SWEEP_RANGE, 1'b1);
		add_row(g_mbinit, d_rsp, 8'h13, info_a, 4'd4, 3'd0, 1'b1, 1'b0, SWEEP_RANGE, 1'b1);
		add_row(g_mbinit, d_req, 8'h10, info_a, 4'd7, 3'd0, 1'b1, 1'b0, SWEEP_RANGE, 1'b1);
		add_row(g_mbinit, d_rsp, 8'h10, info_a, 4'd8, 3'd0, 1'b1, 1'b0, SWEEP_RANGE, 1'b1);
		add_row(g_mbinit, d_req, 8'h14, info_a, 4'd5, 3'd6, 1'b1, 1'b0, SWEEP_RANGE, 1'b1);
		add_row(g_mbinit, d_rsp, 8'h14, info_a, 4'd6, 3'd0, 1'b1, 1'b0, SWEEP_RANGE, 1'b1);
		// main-band train
		add_row(g_mbtrain, d_req, 8'h00, info_a, 4'd1, 3'd0, 1'b1, 1'b0, SWEEP_RANGE, 1'b1);
		add_row(g_mbtrain, d_rsp, 8'h1B, info_a, 4'd2, 3'd0, 1'b1, 1'b0, SWEEP_RANGE, 1'b1);
		add_row(g_mbtrain, d_req, 8'h01, info_a, 4'd3, 3'd0, 1'b1, 1'b0, SWEEP_RANGE, 1'b1);
		add_row(g_mbtrain, d_rsp, 8'h1C, info_a, 4'd4, 3'd0, 1'b1, 1'b0, SWEEP_RANGE, 1'b1);
		add_row(g_mbtrain, d_req, 8'h17, info_a, 4'd5, 3'd0, 1'b1, 1'b0, SWEEP_RANGE, 1'b1);
		add_row(g_mbtrain, d_rsp, 8'h1D, info_a, 4'd6, 3'd0, 1'b1, 1'b0, SWEEP_RANGE, 1'b1);
		add_row(g_mbtrain, d_req, 8'h18, info_a, 4'd7, 3'd0, 1'b1, 1'b0, SWEEP_RANGE, 1'b1);
		add_row(g_mbtrain, d_rsp, 8'h18, info_a, 4'd8, 3'd0, 1'b1, 1'b0, SWEEP_RANGE, 1'b1);
		add_row(g_mbtrain, d_req, 8'h1E, info_a, 4'd7, 3'd6, 1'b1, 1'b0, SWEEP_RANGE, 1'b1);
		add_row(g_mbtrain, d_rsp, 8'h1E, info_a, 4'd8, 3'd0, 1'b1, 1'b0, SWEEP_RANGE, 1'b1);
		add_row(g_mbtrain, d_req, 8'h19, info_a, 4'd9, 3'd0, 1'b1, 1'b0, SWEEP_RANGE, 1'b1);
		add_row(g_mbtrain, d_rsp, 8'h19, info_a, 4'd10, 3'd0, 1'b1, 1'b0, SWEEP_RANGE, 1'b1);
		add_row(g_mbtrain, d_req, 8'h1F, info_a, 4'd11, 3'd0, 1'b1, 1'b0, SWEEP_RANGE, 1'b1);
		add_row(g_mbtrain, d_rsp, 8'h1F, info_a, 4'd12, 3'd0, 1'b1, 1'b0, SWEEP_RANGE, 1'b1);
		// train error then retrain
		add_row(g_trainerr, d_req, 8'h00, info_a, 4'd15, 3'd0, 1'b1, 1'b0, SWEEP_RANGE, 1'b1);
		add_row(g_trainerr, d_rsp, 8'h00, info_a, 4'd14, 3'd0, 1'b1, 1'b0, SWEEP_RANGE, 1'b1);
		add_row(g_retrain, d_req, 8'h01, info_a, 4'd1, 3'd6, 1'b1, 1'b0, SWEEP_RANGE, 1'b1);
		add_row(g_retrain, d_rsp, 8'h01, info_b, 4'd2, 3'd1, 1'b1, 1'b0, SWEEP_RANGE, 1'b1);
		// misses hold the retrain number and nonzero info
		add_row(g_test, d_req, 8'h05, info_a, 4'd0, 3'd0, 1'b0, 1'b1, SWEEP_RANGE, 1'b1);
		add_row(g_test, d_bad, 8'h01, info_a, 4'd0, 3'd0, 1'b0, 1'b1, SWEEP_POINT, 1'b0);
		add_row(g_mbtrain, d_req, 8'h1A, info_a, 4'd0, 3'd0, 1'b0, 1'b0, SWEEP_POINT, 1'b1);
		add_row(g_bad, d_req, 8'h00, info_a, 4'd0, 3'd0, 1'b0, 1'b0, SWEEP_POINT, 1'b1);
		add_row(g_retrain, d_rsp, 8'h02, info_b, 4'd0, 3'd0, 1'b0, 1'b0, SWEEP_POINT, 1'b1);
		// hit again after the misses
		add_row(g_mbinit, d_rsp, 8'h09, info_b, 4'd2, 3'd0, 1'b1, 1'b0, SWEEP_POINT, 1'b1);
	endtask

	// --------------------
	// main sequence
	// --------------------

	initial
	begin
		row_t r;
		void'($urandom(32'h545b));
		rst_n    = 1'b0;
		start_en = 1'b0;
		header   = '0;
		exp_no   = 4'd0;
		exp_info = 3'd0;
		exp_sen  = 1'b0;
		exp_type = SWEEP_POINT;
		fill_table();

		// reset for two cycles
		repeat (2) @(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);
		check_outputs("after reset", 1'b0);

		for (int i = 0; i < rows.size(); i++)
		begin
			r        = rows[i];
			start_en = 1'b1;
			header   = build_header(r);
			@(negedge clk);
			// model update for the start edge just taken
			if (r.hit)
			begin
				exp_no   = r.no;
				exp_info = r.oinfo;
			end
			exp_sen  = r.sen;
			exp_type = r.stype;
			check_outputs($sformatf("row %0d", i), 1'b1);
			if (r.gap)
			begin
				// idle cycle, header junk must be ignored
				start_en = 1'b0;
				header   = {$urandom, $urandom};
				@(negedge clk);
				check_outputs($sformatf("row %0d idle", i), 1'b0);
			end
		end

		start_en = 1'b0;
		@(negedge clk);
		$display("checks: %0d, errors: %0d, assertion failures: %0d", checks, errors,
			dut_i.checker_i.fail_count);
		if (errors == 0 && dut_i.checker_i.fail_count == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

// File: sim.f
+incdir+hw
hw/sb_hdr_pkg.sv
hw/sb_hdr_class_if.sv
hw/sb_msg_classifier.sv
hw/sb_msg_number_lut.sv
hw/sb_rx_hdr_regs.sv
hw/sb_rx_header_decoder.sv
dv/sb_rx_header_decoder_checker.sv
dv/sb_rx_header_decoder_tb.sv

// File: Makefile
# Verilator simulation of the sideband header decoder

VERILATOR ?= verilator
TOP       ?= sb_rx_header_decoder_tb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
TIMESCALE ?= 1ns/1ps
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --timescale $(TIMESCALE) --top-module $(TOP) \
		-f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Regression failed" $(LOG); then exit 1; fi
	@if ! grep -q "Regression passed" $(LOG); then \
		echo "simulation ended without a pass result"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
